/* logic/flight_rate_pkg.sv */
package flight_rate_pkg;

	// target rate, angle error and pid output in signed 12.4 deg/s
	typedef logic signed [15:0] rate_t;

	// measured imu rate in signed hundredths of a degree per second
	typedef logic signed [15:0] imu_rate_t;

	// products and accumulators inside the pid
	typedef logic signed [31:0] acc_t;

	// unsigned motor command
	typedef logic [11:0] motor_t;

	// signed working width of the mixer sums
	typedef logic signed [17:0] mix_t;

	// sequencing of one control cycle
	typedef enum logic [1:0] {
		waiting,
		starting,
		active,
		complete
	} ctrl_state_t;

	// steps of one pid evaluation
	typedef enum logic [2:0] {
		idle,
		error,
		p_term,
		i_term,
		d_term,
		sum,
		done
	} pid_state_t;

	// integral windup bound, symmetric
	localparam acc_t integral_limit = 32'sd16000;

	// pid output range, the full rate_t span
	localparam acc_t rate_max = 32'sd32767;
	localparam acc_t rate_min = -32'sd32768;

	// top of the motor command range
	localparam motor_t motor_max = 12'd4095;

	// hundredths to 12.4 is x * 16 / 100, close to x * 41 / 256
	localparam acc_t imu_scale_mul = 32'sd41;
	localparam int imu_scale_shift = 8;

endpackage

/* logic/axis_pid_if.sv */
`timescale 1ns/1ns

interface axis_pid_if;

	// latched operands from the controller
	flight_rate_pkg::rate_t target;
	flight_rate_pkg::imu_rate_t actual;
	flight_rate_pkg::rate_t angle_error;

	// go rises once the operands are stable
	logic go;
	// high while the controller sits in waiting
	logic release_n;

	// status and result from the pid
	logic active;
	logic complete;
	flight_rate_pkg::rate_t rate_out;

	modport ctrl (
		output target, actual, angle_error,
		output go, release_n,
		input active, complete, rate_out
	);

	modport pid (
		input target, actual, angle_error,
		input go, release_n,
		output active, complete, rate_out
	);

endinterface

/* logic/rate_pid.sv */
`timescale 1ns/1ns

module rate_pid #(
	parameter int kp = 8,
	parameter int ki = 1,
	parameter int kd = 2,
	parameter int gain_shift = 4,
	parameter bit has_angle_term = 1'b1
) (
	input logic start_signal,
	input logic resetn,
	axis_pid_if.pid ax
);

	flight_rate_pkg::pid_state_t state;
	flight_rate_pkg::pid_state_t next_state;

	// persistent loop state, cleared by reset only
	flight_rate_pkg::acc_t integral;
	flight_rate_pkg::acc_t err_prev;
	flight_rate_pkg::rate_t rate_q;

	// per cycle working values
	flight_rate_pkg::acc_t err;
	flight_rate_pkg::acc_t p_prod;
	flight_rate_pkg::acc_t i_prod;
	flight_rate_pkg::acc_t d_prod;

	// shared multiplier
	flight_rate_pkg::acc_t mul_a;
	flight_rate_pkg::acc_t mul_b;
	flight_rate_pkg::acc_t product;

	flight_rate_pkg::acc_t scaled;
	flight_rate_pkg::acc_t angle_term;
	flight_rate_pkg::acc_t err_next;
	flight_rate_pkg::acc_t integ_sum;
	flight_rate_pkg::acc_t integ_sat;
	flight_rate_pkg::acc_t total;
	flight_rate_pkg::acc_t shifted;
	flight_rate_pkg::rate_t rate_sat;

	always_comb begin
		next_state = state;
		case (state)
			flight_rate_pkg::idle:   if (ax.go) next_state = flight_rate_pkg::error;
			flight_rate_pkg::error:  next_state = flight_rate_pkg::p_term;
			flight_rate_pkg::p_term: next_state = flight_rate_pkg::i_term;
			flight_rate_pkg::i_term: next_state = flight_rate_pkg::d_term;
			flight_rate_pkg::d_term: next_state = flight_rate_pkg::sum;
			flight_rate_pkg::sum:    next_state = flight_rate_pkg::done;
			flight_rate_pkg::done:   if (ax.release_n) next_state = flight_rate_pkg::idle;
			default:                 next_state = flight_rate_pkg::idle;
		endcase
	end

	// integral update with windup clamp
	assign integ_sum = integral + err;
	always_comb begin
		if (integ_sum > flight_rate_pkg::integral_limit)
			integ_sat = flight_rate_pkg::integral_limit;
		else if (integ_sum < -flight_rate_pkg::integral_limit)
			integ_sat = -flight_rate_pkg::integral_limit;
		else
			integ_sat = integ_sum;
	end

	// operand select, one product per step
	always_comb begin
		mul_a = '0;
		mul_b = '0;
		case (state)
			flight_rate_pkg::error: begin
				mul_a = flight_rate_pkg::acc_t'(ax.actual);
				mul_b = flight_rate_pkg::imu_scale_mul;
			end
			flight_rate_pkg::p_term: begin
				mul_a = err;
				mul_b = flight_rate_pkg::acc_t'(kp);
			end
			flight_rate_pkg::i_term: begin
				mul_a = integ_sat;
				mul_b = flight_rate_pkg::acc_t'(ki);
			end
			flight_rate_pkg::d_term: begin
				mul_a = err - err_prev;
				mul_b = flight_rate_pkg::acc_t'(kd);
			end
			default: ;
		endcase
	end

	assign product = mul_a * mul_b;

	// error term, measured rate rescaled to 12.4
	assign scaled = product >>> flight_rate_pkg::imu_scale_shift;
	assign angle_term = has_angle_term ? flight_rate_pkg::acc_t'(ax.angle_error)
		: flight_rate_pkg::acc_t'(0);
	assign err_next = flight_rate_pkg::acc_t'(ax.target) - scaled + angle_term;

	// output gain and saturation to rate_t
	assign total = p_prod + i_prod + d_prod;
	assign shifted = total >>> gain_shift;
	always_comb begin
		if (shifted > flight_rate_pkg::rate_max)
			rate_sat = flight_rate_pkg::rate_t'(flight_rate_pkg::rate_max);
		else if (shifted < flight_rate_pkg::rate_min)
			rate_sat = flight_rate_pkg::rate_t'(flight_rate_pkg::rate_min);
		else
			rate_sat = flight_rate_pkg::rate_t'(shifted);
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= flight_rate_pkg::idle;
			integral <= '0;
			err_prev <= '0;
			rate_q <= '0;
		end else begin
			state <= next_state;
			if (state == flight_rate_pkg::i_term)
				integral <= integ_sat;
			if (state == flight_rate_pkg::sum)
				rate_q <= rate_sat;
			if (state == flight_rate_pkg::done)
				err_prev <= err;
		end
	end

	always_ff @(posedge start_signal) begin
		case (state)
			flight_rate_pkg::error:  err <= err_next;
			flight_rate_pkg::p_term: p_prod <= product;
			flight_rate_pkg::i_term: i_prod <= product;
			flight_rate_pkg::d_term: d_prod <= product;
			default: ;
		endcase
	end

	// active from the first working step until release
	assign ax.active = (state != flight_rate_pkg::idle);
	assign ax.complete = (state == flight_rate_pkg::done);
	assign ax.rate_out = rate_q;

endmodule

/* logic/body_frame_controller.sv */
`timescale 1ns/1ns

module body_frame_controller (
	input logic start_signal,
	input logic resetn,
	input logic cycle_start,
	input flight_rate_pkg::rate_t yaw_target,
	input flight_rate_pkg::rate_t roll_target,
	input flight_rate_pkg::rate_t pitch_target,
	input flight_rate_pkg::rate_t roll_angle_error,
	input flight_rate_pkg::rate_t pitch_angle_error,
	input flight_rate_pkg::imu_rate_t yaw_rotation,
	input flight_rate_pkg::imu_rate_t roll_rotation,
	input flight_rate_pkg::imu_rate_t pitch_rotation,
	output logic complete_signal,
	axis_pid_if.ctrl yaw_ax,
	axis_pid_if.ctrl roll_ax,
	axis_pid_if.ctrl pitch_ax
);

	flight_rate_pkg::ctrl_state_t state;
	flight_rate_pkg::ctrl_state_t next_state;

	logic start_prev;
	logic accept;
	logic all_active;
	logic all_complete;
	logic go_lvl;
	logic release_lvl;

	// cycle operands, held for the whole cycle
	flight_rate_pkg::rate_t yaw_target_q;
	flight_rate_pkg::rate_t roll_target_q;
	flight_rate_pkg::rate_t pitch_target_q;
	flight_rate_pkg::rate_t roll_angle_q;
	flight_rate_pkg::rate_t pitch_angle_q;
	flight_rate_pkg::imu_rate_t yaw_rot_q;
	flight_rate_pkg::imu_rate_t roll_rot_q;
	flight_rate_pkg::imu_rate_t pitch_rot_q;

	// rising edge of cycle_start, only honoured while waiting
	assign accept = cycle_start && !start_prev && (state == flight_rate_pkg::waiting);

	assign all_active = yaw_ax.active && roll_ax.active && pitch_ax.active;
	assign all_complete = yaw_ax.complete && roll_ax.complete && pitch_ax.complete;

	always_comb begin
		next_state = state;
		case (state)
			flight_rate_pkg::waiting:  if (accept) next_state = flight_rate_pkg::starting;
			flight_rate_pkg::starting: if (all_active) next_state = flight_rate_pkg::active;
			flight_rate_pkg::active:   if (all_complete) next_state = flight_rate_pkg::complete;
			flight_rate_pkg::complete: next_state = flight_rate_pkg::waiting;
			default:                   next_state = flight_rate_pkg::waiting;
		endcase
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= flight_rate_pkg::waiting;
			start_prev <= 1'b0;
		end else begin
			state <= next_state;
			start_prev <= cycle_start;
		end
	end

	always_ff @(posedge start_signal) begin
		if (accept) begin
			yaw_target_q <= yaw_target;
			roll_target_q <= roll_target;
			pitch_target_q <= pitch_target;
			roll_angle_q <= roll_angle_error;
			pitch_angle_q <= pitch_angle_error;
			yaw_rot_q <= yaw_rotation;
			roll_rot_q <= roll_rotation;
			pitch_rot_q <= pitch_rotation;
		end
	end

	// state decodes
	assign go_lvl = (state == flight_rate_pkg::starting) || (state == flight_rate_pkg::active);
	assign release_lvl = (state == flight_rate_pkg::waiting);
	assign complete_signal = (state == flight_rate_pkg::complete);

	assign yaw_ax.target = yaw_target_q;
	assign yaw_ax.actual = yaw_rot_q;
	// yaw has no angle loop above it
	assign yaw_ax.angle_error = '0;
	assign yaw_ax.go = go_lvl;
	assign yaw_ax.release_n = release_lvl;

	assign roll_ax.target = roll_target_q;
	assign roll_ax.actual = roll_rot_q;
	assign roll_ax.angle_error = roll_angle_q;
	assign roll_ax.go = go_lvl;
	assign roll_ax.release_n = release_lvl;

	assign pitch_ax.target = pitch_target_q;
	assign pitch_ax.actual = pitch_rot_q;
	assign pitch_ax.angle_error = pitch_angle_q;
	assign pitch_ax.go = go_lvl;
	assign pitch_ax.release_n = release_lvl;

endmodule

/* logic/motor_mixer.sv */
`timescale 1ns/1ns

module motor_mixer (
	input logic start_signal,
	input logic resetn,
	input logic complete_signal,
	input flight_rate_pkg::motor_t throttle,
	input flight_rate_pkg::rate_t yaw_rate,
	input flight_rate_pkg::rate_t roll_rate,
	input flight_rate_pkg::rate_t pitch_rate,
	output flight_rate_pkg::motor_t motor_fl,
	output flight_rate_pkg::motor_t motor_fr,
	output flight_rate_pkg::motor_t motor_rl,
	output flight_rate_pkg::motor_t motor_rr,
	output logic mix_valid
);

	flight_rate_pkg::mix_t thr_s;
	flight_rate_pkg::mix_t yaw_i;
	flight_rate_pkg::mix_t roll_i;
	flight_rate_pkg::mix_t pitch_i;
	flight_rate_pkg::mix_t sum_fl;
	flight_rate_pkg::mix_t sum_fr;
	flight_rate_pkg::mix_t sum_rl;
	flight_rate_pkg::mix_t sum_rr;

	function automatic flight_rate_pkg::motor_t clamp_motor(input flight_rate_pkg::mix_t v);
		flight_rate_pkg::mix_t top;
		top = flight_rate_pkg::mix_t'(flight_rate_pkg::motor_max);
		if (v < 0)
			return '0;
		else if (v > top)
			return flight_rate_pkg::motor_max;
		else
			return flight_rate_pkg::motor_t'(v);
	endfunction

	// throttle is unsigned, widen before mixing with signed terms
	assign thr_s = flight_rate_pkg::mix_t'(throttle);

	// integer part of each 12.4 rate
	assign yaw_i = flight_rate_pkg::mix_t'(yaw_rate >>> 4);
	assign roll_i = flight_rate_pkg::mix_t'(roll_rate >>> 4);
	assign pitch_i = flight_rate_pkg::mix_t'(pitch_rate >>> 4);

	// quad x layout
	assign sum_fl = thr_s + pitch_i + roll_i - yaw_i;
	assign sum_fr = thr_s + pitch_i - roll_i + yaw_i;
	assign sum_rl = thr_s - pitch_i + roll_i + yaw_i;
	assign sum_rr = thr_s - pitch_i - roll_i - yaw_i;

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			motor_fl <= '0;
			motor_fr <= '0;
			motor_rl <= '0;
			motor_rr <= '0;
			mix_valid <= 1'b0;
		end else begin
			mix_valid <= complete_signal;
			if (complete_signal) begin
				motor_fl <= clamp_motor(sum_fl);
				motor_fr <= clamp_motor(sum_fr);
				motor_rl <= clamp_motor(sum_rl);
				motor_rr <= clamp_motor(sum_rr);
			end
		end
	end

endmodule

/* logic/flight_rate_top.sv */
`timescale 1ns/1ns

module flight_rate_top #(
	parameter int kp = 8,
	parameter int ki = 1,
	parameter int kd = 2,
	parameter int gain_shift = 4
) (
	input logic start_signal,
	input logic resetn,
	input logic cycle_start,
	input flight_rate_pkg::rate_t yaw_target,
	input flight_rate_pkg::rate_t roll_target,
	input flight_rate_pkg::rate_t pitch_target,
	input flight_rate_pkg::rate_t roll_angle_error,
	input flight_rate_pkg::rate_t pitch_angle_error,
	input flight_rate_pkg::imu_rate_t yaw_rotation,
	input flight_rate_pkg::imu_rate_t roll_rotation,
	input flight_rate_pkg::imu_rate_t pitch_rotation,
	input flight_rate_pkg::motor_t throttle,
	output flight_rate_pkg::rate_t yaw_rate_out,
	output flight_rate_pkg::rate_t roll_rate_out,
	output flight_rate_pkg::rate_t pitch_rate_out,
	output logic complete_signal,
	output flight_rate_pkg::motor_t motor_fl,
	output flight_rate_pkg::motor_t motor_fr,
	output flight_rate_pkg::motor_t motor_rl,
	output flight_rate_pkg::motor_t motor_rr,
	output logic mix_valid
);

	axis_pid_if yaw_if ();
	axis_pid_if roll_if ();
	axis_pid_if pitch_if ();

	body_frame_controller ctrl_i (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.roll_angle_error(roll_angle_error),
		.pitch_angle_error(pitch_angle_error),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.complete_signal(complete_signal),
		.yaw_ax(yaw_if.ctrl),
		.roll_ax(roll_if.ctrl),
		.pitch_ax(pitch_if.ctrl)
	);

	// same gains on all axes, yaw without angle term
	rate_pid #(.kp(kp), .ki(ki), .kd(kd), .gain_shift(gain_shift), .has_angle_term(1'b0))
	yaw_pid (.start_signal(start_signal), .resetn(resetn), .ax(yaw_if.pid));

	rate_pid #(.kp(kp), .ki(ki), .kd(kd), .gain_shift(gain_shift), .has_angle_term(1'b1))
	roll_pid (.start_signal(start_signal), .resetn(resetn), .ax(roll_if.pid));

	rate_pid #(.kp(kp), .ki(ki), .kd(kd), .gain_shift(gain_shift), .has_angle_term(1'b1))
	pitch_pid (.start_signal(start_signal), .resetn(resetn), .ax(pitch_if.pid));

	assign yaw_rate_out = yaw_if.rate_out;
	assign roll_rate_out = roll_if.rate_out;
	assign pitch_rate_out = pitch_if.rate_out;

	motor_mixer mixer_i (
		.start_signal(start_signal),
		.resetn(resetn),
		.complete_signal(complete_signal),
		.throttle(throttle),
		.yaw_rate(yaw_if.rate_out),
		.roll_rate(roll_if.rate_out),
		.pitch_rate(pitch_if.rate_out),
		.motor_fl(motor_fl),
		.motor_fr(motor_fr),
		.motor_rl(motor_rl),
		.motor_rr(motor_rr),
		.mix_valid(mix_valid)
	);

endmodule

/* tb/flight_rate_tb.sv */
`timescale 1ns/1ns

module flight_rate_tb;

	localparam int kp = 8;
	localparam int ki = 1;
	localparam int kd = 2;
	localparam int gain_shift = 4;

	logic start_signal;
	logic resetn;
	logic cycle_start;
	flight_rate_pkg::rate_t yaw_target;
	flight_rate_pkg::rate_t roll_target;
	flight_rate_pkg::rate_t pitch_target;
	flight_rate_pkg::rate_t roll_angle_error;
	flight_rate_pkg::rate_t pitch_angle_error;
	flight_rate_pkg::imu_rate_t yaw_rotation;
	flight_rate_pkg::imu_rate_t roll_rotation;
	flight_rate_pkg::imu_rate_t pitch_rotation;
	flight_rate_pkg::motor_t throttle;
	flight_rate_pkg::rate_t yaw_rate_out;
	flight_rate_pkg::rate_t roll_rate_out;
	flight_rate_pkg::rate_t pitch_rate_out;
	logic complete_signal;
	flight_rate_pkg::motor_t motor_fl;
	flight_rate_pkg::motor_t motor_fr;
	flight_rate_pkg::motor_t motor_rl;
	flight_rate_pkg::motor_t motor_rr;
	logic mix_valid;

	int value_errors = 0;
	int other_errors = 0;
	int complete_count = 0;
	bit timed_out = 1'b0;
	logic [31:0] lcg_state;

	// model state per axis, 0 yaw, 1 roll, 2 pitch
	longint integ_m [3];
	longint prev_m [3];

	flight_rate_top #(.kp(kp), .ki(ki), .kd(kd), .gain_shift(gain_shift)) dut_i (.*);

	initial begin
		start_signal = 1'b0;
		forever #5 start_signal = ~start_signal;
	end

	always @(posedge start_signal) begin
		if (complete_signal)
			complete_count++;
	end

	assert property (@(posedge start_signal) disable iff (!resetn)
		complete_signal |=> !complete_signal)
	else begin
		other_errors++;
		$display("complete_signal was high for more than one cycle");
	end

	assert property (@(posedge start_signal) disable iff (!resetn)
		complete_signal |=> mix_valid)
	else begin
		other_errors++;
		$display("mix_valid did not rise one cycle after complete_signal");
	end

	assert property (@(posedge start_signal) disable iff (!resetn)
		!complete_signal |=> !mix_valid)
	else begin
		other_errors++;
		$display("mix_valid was high without complete_signal in the cycle before");
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// span 0 stays within +-2048, 1 covers the full 16 bits, 2 and 3 pin the extremes
	function automatic logic signed [15:0] rand_rate(input int span);
		logic [31:0] r;
		r = next_random();
		if (span == 2)
			return 16'sh7fff;
		if (span == 3)
			return 16'sh8000;
		if (span == 1)
			return r[23:8];
		return {{4{r[19]}}, r[19:8]};
	endfunction

	function automatic longint pid_model(input int axis, input longint target,
		input longint actual, input longint angle);
		longint e;
		longint lim;
		longint total;
		lim = longint'(flight_rate_pkg::integral_limit);
		// hundredths of a degree to 12.4
		e = target - ((actual * 64'sd41) >>> 8) + angle;
		integ_m[axis] = integ_m[axis] + e;
		if (integ_m[axis] > lim)
			integ_m[axis] = lim;
		else if (integ_m[axis] < -lim)
			integ_m[axis] = -lim;
		total = longint'(kp) * e + longint'(ki) * integ_m[axis]
			+ longint'(kd) * (e - prev_m[axis]);
		prev_m[axis] = e;
		total = total >>> gain_shift;
		if (total > 64'sd32767)
			return 64'sd32767;
		if (total < -64'sd32768)
			return -64'sd32768;
		return total;
	endfunction

	function automatic longint motor_model(input longint sum);
		longint top;
		top = longint'(flight_rate_pkg::motor_max);
		if (sum < 64'sd0)
			return 64'sd0;
		if (sum > top)
			return top;
		return sum;
	endfunction

	task automatic check_value(input string name, input longint expected, input longint actual);
		assert (expected == actual)
		else begin
			value_errors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic record_timeout(input string what);
		other_errors++;
		timed_out = 1'b1;
		$display("timeout: %s", what);
	endtask

	// mode 0 plain pulse, 1 start held high, 2 extra pulses while busy
	task automatic run_cycle(input int mode, input int span, input flight_rate_pkg::motor_t thr);
		longint exp_rate [3];
		longint yaw_i;
		longint roll_i;
		longint pitch_i;
		longint thr_l;
		int cnt;
		int start_count;
		start_count = complete_count;
		yaw_target = rand_rate(span);
		roll_target = rand_rate(span);
		pitch_target = rand_rate(span);
		roll_angle_error = rand_rate(span);
		pitch_angle_error = rand_rate(span);
		yaw_rotation = rand_rate(span);
		roll_rotation = rand_rate(span);
		pitch_rotation = rand_rate(span);
		throttle = thr;
		cycle_start = 1'b1;
		exp_rate[0] = pid_model(0, longint'(yaw_target), longint'(yaw_rotation), 64'sd0);
		exp_rate[1] = pid_model(1, longint'(roll_target), longint'(roll_rotation),
			longint'(roll_angle_error));
		exp_rate[2] = pid_model(2, longint'(pitch_target), longint'(pitch_rotation),
			longint'(pitch_angle_error));
		cnt = 0;
		while (!complete_signal && cnt < 20) begin
			@(negedge start_signal);
			cnt++;
			if (mode == 1)
				cycle_start = 1'b1;
			else if (mode == 2 && cnt >= 2 && cnt <= 5)
				cycle_start = ~cycle_start;
			else
				cycle_start = 1'b0;
		end
		if (!complete_signal) begin
			record_timeout("complete_signal did not rise after cycle_start");
			return;
		end
		// the first negedge already lies after the sampling edge
		check_value("complete_signal latency", 64'sd7, longint'(cnt - 1));
		check_value("yaw_rate_out", exp_rate[0], longint'(yaw_rate_out));
		check_value("roll_rate_out", exp_rate[1], longint'(roll_rate_out));
		check_value("pitch_rate_out", exp_rate[2], longint'(pitch_rate_out));
		cnt = 0;
		while (!mix_valid && cnt < 4) begin
			@(negedge start_signal);
			cnt++;
		end
		if (!mix_valid) begin
			record_timeout("mix_valid did not follow complete_signal");
			return;
		end
		// integer part of each rate
		yaw_i = exp_rate[0] >>> 4;
		roll_i = exp_rate[1] >>> 4;
		pitch_i = exp_rate[2] >>> 4;
		thr_l = longint'(thr);
		check_value("motor_fl", motor_model(thr_l + pitch_i + roll_i - yaw_i), longint'(motor_fl));
		check_value("motor_fr", motor_model(thr_l + pitch_i - roll_i + yaw_i), longint'(motor_fr));
		check_value("motor_rl", motor_model(thr_l - pitch_i + roll_i + yaw_i), longint'(motor_rl));
		check_value("motor_rr", motor_model(thr_l - pitch_i - roll_i - yaw_i), longint'(motor_rr));
		// idle gap, a held start stays high through waiting
		repeat (10) @(negedge start_signal);
		cycle_start = 1'b0;
		repeat (2) @(negedge start_signal);
		check_value("complete_signal pulses", 64'sd1, longint'(complete_count - start_count));
	endtask

	initial begin
		flight_rate_pkg::motor_t thr;
		lcg_state = 32'h8656;
		foreach (integ_m[k]) begin
			integ_m[k] = 64'sd0;
			prev_m[k] = 64'sd0;
		end
		resetn = 1'b0;
		cycle_start = 1'b0;
		yaw_target = '0;
		roll_target = '0;
		pitch_target = '0;
		roll_angle_error = '0;
		pitch_angle_error = '0;
		yaw_rotation = '0;
		roll_rotation = '0;
		pitch_rotation = '0;
		throttle = '0;
		repeat (5) @(posedge start_signal);
		@(negedge start_signal);
		resetn = 1'b1;

		// quiet outputs before the first cycle
		repeat (5) begin
			@(negedge start_signal);
			check_value("complete_signal", 64'sd0, longint'(complete_signal));
			check_value("mix_valid", 64'sd0, longint'(mix_valid));
			check_value("yaw_rate_out", 64'sd0, longint'(yaw_rate_out));
			check_value("roll_rate_out", 64'sd0, longint'(roll_rate_out));
			check_value("pitch_rate_out", 64'sd0, longint'(pitch_rate_out));
			check_value("motor_fl", 64'sd0, longint'(motor_fl));
			check_value("motor_fr", 64'sd0, longint'(motor_fr));
			check_value("motor_rl", 64'sd0, longint'(motor_rl));
			check_value("motor_rr", 64'sd0, longint'(motor_rr));
		end

		// throttle at both ends now and then to reach the clamps
		for (int i = 0; i < 30 && !timed_out; i++) begin
			if (i % 7 == 0)
				thr = 12'd0;
			else if (i % 7 == 1)
				thr = 12'd4095;
			else
				thr = flight_rate_pkg::motor_t'(next_random() >> 20);
			run_cycle(0, (i % 4 == 3) ? 1 : 0, thr);
		end
		// pinned extremes push roll and pitch into saturation both ways
		if (!timed_out)
			run_cycle(0, 2, 12'd2048);
		if (!timed_out)
			run_cycle(0, 3, 12'd2048);
		if (!timed_out)
			run_cycle(1, 0, 12'd2048);
		if (!timed_out)
			run_cycle(2, 0, 12'd1024);

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* flight_rate.f */
logic/flight_rate_pkg.sv
logic/axis_pid_if.sv
logic/rate_pid.sv
logic/body_frame_controller.sv
logic/motor_mixer.sv
logic/flight_rate_top.sv
tb/flight_rate_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f flight_rate.f \
	--top-module flight_rate_tb -o flight_rate_sim

out=$(./obj_dir/flight_rate_sim)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
	exit 0
fi
exit 1
